// File: src/zx_pkg.sv
/*
 * Machine type, video timing sizes, screen pages and port decode masks
 */
package zx_pkg;

    typedef enum logic {
        MACHINE_48,
        MACHINE_PENT
    } machine_t;

    // --------------------------------------------------
    // Video timing
    // --------------------------------------------------
    localparam logic [8:0] H_TOTAL      = 9'd448;
    localparam logic [8:0] V_TOTAL_48   = 9'd312;
    localparam logic [8:0] V_TOTAL_PENT = 9'd320;

    // Paper area, in pixels and lines
    localparam logic [8:0] H_PAPER = 9'd256;
    localparam logic [8:0] V_PAPER = 9'd192;

    // --------------------------------------------------
    // Paging and I/O decode
    // --------------------------------------------------
    localparam logic [2:0] PAGE_SCREEN0 = 3'd5;
    localparam logic [2:0] PAGE_SCREEN1 = 3'd7;

    // A port is selected when all masked address bits are low
    localparam logic [15:0] PORT_FE_MASK   = 16'h0001;
    localparam logic [15:0] PORT_7FFD_MASK = 16'h8002;

endpackage

// File: src/cpu_bus.sv
`timescale 1ns/1ps

/*
 * Decoded Z80 bus, all strobes active high
 */
interface cpu_bus;

    logic [15:0] a;
    logic [7:0]  d;
    logic        mreq;
    logic        iorq;
    logic        rd;
    logic        wr;
    logic        m1;
    logic        rfsh;
    // I/O cycle that is not an interrupt acknowledge
    logic        ioreq;

    // Driven from the pins at the top level
    modport src (
        output a, d,
        output mreq, iorq, rd, wr, m1, rfsh,
        output ioreq
    );

    // Seen by the blocks that decode CPU cycles
    modport snk (
        input a, d,
        input mreq, iorq, rd, wr, m1, rfsh,
        input ioreq
    );

endinterface

// File: src/screen.sv
`timescale 1ns/1ps

/*
 * Line and frame counters, syncs, screen fetch requests and RGB output
 */
module screen (
    input  logic             clk28,
    input  logic             usrrst_n,
    input  zx_pkg::machine_t machine,
    input  logic [2:0]       border,
    input  logic             fetch_allow,
    input  logic [7:0]       fetch_data,
    output logic [8:0]       hc,
    output logic [8:0]       vc,
    output logic             ck7,
    output logic             hsync,
    output logic             vsync,
    output logic [1:0]       r,
    output logic [1:0]       g,
    output logic [1:0]       b,
    output logic             fetch,
    output logic [13:0]      addr
);
    import zx_pkg::*;

    localparam logic [8:0] HSYNC_BEG = 9'd344;
    localparam logic [8:0] HSYNC_END = 9'd376;
    localparam logic [8:0] VSYNC_BEG = 9'd248;
    localparam logic [8:0] VSYNC_END = 9'd252;
    // Paper is shown one cell after it is fetched
    localparam logic [8:0] PAPER_DLY = 9'd8;

    logic [1:0] div4;
    logic [8:0] v_total;
    logic [8:0] hc_next;
    logic [8:0] vc_next;
    logic       cell_tick;
    logic       fetch_area;
    logic       paper;
    logic       attr_phase;
    logic       capture;
    logic [4:0] col_q;
    logic [7:0] row_q;
    logic [7:0] bmp_next;
    logic [7:0] attr_next;
    logic [7:0] pix_sr;
    logic [7:0] attr_q;
    logic [2:0] colour;
    logic       bright;

    // --------------------------------------------------
    // Counters and syncs
    // --------------------------------------------------
    assign ck7 = &div4;
    assign v_total = (machine == MACHINE_PENT) ? V_TOTAL_PENT : V_TOTAL_48;
    assign hc_next = (hc == H_TOTAL - 9'd1) ? 9'd0 : hc + 9'd1;

    always_comb begin
        vc_next = vc;
        if (hc == H_TOTAL - 9'd1) begin
            vc_next = (vc == v_total - 9'd1) ? 9'd0 : vc + 9'd1;
        end
    end

    always_ff @(posedge clk28 or negedge usrrst_n) begin
        if (!usrrst_n) begin
            div4 <= 2'd0;
            hc <= 9'd0;
            vc <= 9'd0;
        end else begin
            div4 <= div4 + 2'd1;
            if (ck7) begin
                hc <= hc_next;
                vc <= vc_next;
            end
        end
    end

    assign hsync = ~((hc >= HSYNC_BEG) && (hc < HSYNC_END));
    assign vsync = ~((vc >= VSYNC_BEG) && (vc < VSYNC_END));

    // --------------------------------------------------
    // Fetch, bitmap byte then attribute byte per cell
    // --------------------------------------------------
    assign cell_tick = ck7 && (hc[2:0] == 3'd7);
    assign fetch_area = (vc_next < V_PAPER) && (hc_next < H_PAPER);

    always_ff @(posedge clk28 or negedge usrrst_n) begin
        if (!usrrst_n) begin
            fetch <= 1'b0;
            attr_phase <= 1'b0;
            capture <= 1'b0;
        end else begin
            capture <= fetch && fetch_allow;
            if (fetch && fetch_allow) begin
                fetch <= 1'b0;
            end
            if (capture && !attr_phase) begin
                attr_phase <= 1'b1;
                fetch <= 1'b1;
            end
            // New cell restarts the sequence
            if (cell_tick && fetch_area) begin
                fetch <= 1'b1;
                attr_phase <= 1'b0;
                capture <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk28) begin
        if (cell_tick && fetch_area) begin
            col_q <= hc_next[7:3];
            row_q <= vc_next[7:0];
        end
        if (capture) begin
            if (attr_phase) begin
                attr_next <= fetch_data;
            end else begin
                bmp_next <= fetch_data;
            end
        end
        if (cell_tick) begin
            pix_sr <= bmp_next;
            attr_q <= attr_next;
        end else if (ck7) begin
            pix_sr <= {pix_sr[6:0], 1'b0};
        end
    end

    assign addr = attr_phase ? {4'b0110, row_q[7:3], col_q}
                             : {1'b0, row_q[7:6], row_q[2:0], row_q[5:3], col_q};

    // --------------------------------------------------
    // Colour
    // --------------------------------------------------
    assign paper = (vc < V_PAPER) && (hc >= PAPER_DLY) && (hc < H_PAPER + PAPER_DLY);

    always_comb begin
        colour = border;
        bright = 1'b1;
        if (paper) begin
            colour = pix_sr[7] ? attr_q[2:0] : attr_q[5:3];
            bright = attr_q[6];
        end
    end

    // G R B order in the attribute byte
    assign r = {colour[1], colour[1] & bright};
    assign g = {colour[2], colour[2] & bright};
    assign b = {colour[0], colour[0] & bright};

endmodule

// File: src/cpucontrol.sv
`timescale 1ns/1ps

/*
 * CPU clock divider and frame interrupt
 */
module cpucontrol #(
    parameter int INT_LEN = 32
) (
    input  logic       clk28,
    input  logic       usrrst_n,
    input  logic [8:0] hc,
    input  logic [8:0] vc,
    cpu_bus.snk        bus,
    output logic       clkcpu,
    output logic       n_int
);

    // One CPU clock is eight clk28 cycles
    localparam int INT_CYCLES = INT_LEN * 8;
    localparam int CNT_W = $clog2(INT_CYCLES + 1);

    logic [2:0]       div8;
    logic             frame_zero;
    logic             frame_zero_q;
    logic             int_ack;
    logic [CNT_W-1:0] int_cnt;

    // --------------------------------------------------
    // 3.5 MHz clock
    // --------------------------------------------------
    always_ff @(posedge clk28 or negedge usrrst_n) begin
        if (!usrrst_n) begin
            div8 <= 3'd0;
        end else begin
            div8 <= div8 + 3'd1;
        end
    end

    assign clkcpu = div8[2];

    // --------------------------------------------------
    // Interrupt pulse
    // --------------------------------------------------
    assign frame_zero = (hc == 9'd0) && (vc == 9'd0);
    assign int_ack = bus.m1 & bus.iorq;

    // frame_zero_q starts high so the first pulse comes with the next frame
    always_ff @(posedge clk28 or negedge usrrst_n) begin
        if (!usrrst_n) begin
            frame_zero_q <= 1'b1;
            n_int <= 1'b1;
            int_cnt <= '0;
        end else begin
            frame_zero_q <= frame_zero;
            if (frame_zero && !frame_zero_q) begin
                n_int <= 1'b0;
                int_cnt <= '0;
            end else if (!n_int) begin
                if (int_ack || (int_cnt == CNT_W'(INT_CYCLES - 1))) begin
                    n_int <= 1'b1;
                end else begin
                    int_cnt <= int_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: src/ports.sv
`timescale 1ns/1ps

/*
 * Port #FE (border, beeper, keyboard) and port #7FFD (128K paging)
 */
module ports (
    input  logic       clk28,
    input  logic       usrrst_n,
    cpu_bus.snk        bus,
    input  logic [4:0] kd,
    output logic [2:0] border,
    output logic       beeper,
    output logic [2:0] rampage,
    output logic       screenpage,
    output logic       rompage,
    output logic [7:0] d_out,
    output logic       d_out_active
);
    import zx_pkg::*;

    logic        io_wr;
    logic        io_wr_q;
    logic        wr_take;
    logic [15:0] wr_a;
    logic [7:0]  wr_d;
    logic        lock_7ffd;

    function automatic logic port_sel(input logic [15:0] a, input logic [15:0] mask);
        return (a & mask) == 16'h0000;
    endfunction

    // --------------------------------------------------
    // Writes, captured on the first edge and applied on the next
    // --------------------------------------------------
    assign io_wr = bus.ioreq & bus.wr;

    always_ff @(posedge clk28) begin
        if (io_wr && !io_wr_q) begin
            wr_a <= bus.a;
            wr_d <= bus.d;
        end
    end

    always_ff @(posedge clk28 or negedge usrrst_n) begin
        if (!usrrst_n) begin
            io_wr_q <= 1'b0;
            wr_take <= 1'b0;
            border <= 3'd0;
            beeper <= 1'b0;
            rampage <= 3'd0;
            screenpage <= 1'b0;
            rompage <= 1'b0;
            lock_7ffd <= 1'b0;
        end else begin
            io_wr_q <= io_wr;
            wr_take <= io_wr & ~io_wr_q;
            if (wr_take && port_sel(wr_a, PORT_FE_MASK)) begin
                border <= wr_d[2:0];
                beeper <= wr_d[4];
            end
            // Bit 5 locks paging until reset
            if (wr_take && port_sel(wr_a, PORT_7FFD_MASK) && !lock_7ffd) begin
                rampage <= wr_d[2:0];
                screenpage <= wr_d[3];
                rompage <= wr_d[4];
                lock_7ffd <= wr_d[5];
            end
        end
    end

    // Keyboard read, rows already combined on the pins
    assign d_out_active = bus.ioreq & bus.rd & port_sel(bus.a, PORT_FE_MASK);
    assign d_out = {3'b111, kd};

endmodule

// File: src/memcontrol.sv
`timescale 1ns/1ps

/*
 * CPU address mapping, screen fetch arbitration, RAM/ROM strobes and data-out mux
 */
module memcontrol (
    input  logic         clk28,
    input  logic         usrrst_n,
    cpu_bus.snk          bus,
    input  logic         screen_fetch,
    input  logic [13:0]  screen_addr,
    input  logic [2:0]   rampage,
    input  logic         screenpage,
    input  logic         rompage,
    input  logic [7:0]   vd_in,
    input  logic [7:0]   d_out,
    input  logic         d_out_active,
    output logic         fetch_allow,
    output logic [7:0]   fetch_data,
    output logic [18:0]  va,
    output logic [7:0]   vd_out,
    output logic         n_vrd,
    output logic         n_vwr,
    output logic         n_romcs,
    output logic [15:14] ra,
    output logic [7:0]   xd_out,
    output logic         xd_oe
);
    import zx_pkg::*;

    logic        cpu_mem;
    logic        rom_area;
    logic        cpu_ram_rd;
    logic        cpu_ram_wr;
    logic [2:0]  cpu_page;
    logic [2:0]  scr_page;
    logic        scr_grant;
    logic        scr_phase;
    logic [16:0] scr_va_q;

    // --------------------------------------------------
    // Address mapping
    // --------------------------------------------------
    assign cpu_mem = bus.mreq & ~bus.rfsh;
    assign rom_area = (bus.a[15:14] == 2'b00);
    assign cpu_ram_rd = cpu_mem & ~rom_area & bus.rd;
    assign cpu_ram_wr = cpu_mem & ~rom_area & bus.wr;

    always_comb begin
        case (bus.a[15:14])
            2'b01: cpu_page = PAGE_SCREEN0;
            2'b10: cpu_page = 3'd2;
            2'b11: cpu_page = rampage;
            default: cpu_page = 3'd0;
        endcase
    end

    assign n_romcs = ~(cpu_mem & rom_area);
    assign ra = {1'b0, rompage};

    // Screen reads only while the CPU leaves the bus free
    assign fetch_allow = ~bus.mreq | bus.rfsh;
    assign scr_grant = screen_fetch & fetch_allow;
    assign scr_page = screenpage ? PAGE_SCREEN1 : PAGE_SCREEN0;
    assign fetch_data = vd_in;

    always_ff @(posedge clk28) begin
        if (scr_grant) begin
            scr_va_q <= {scr_page, screen_addr};
        end
    end

    always_comb begin
        if (scr_phase) begin
            va = {2'b00, scr_va_q};
        end else if (scr_grant) begin
            va = {2'b00, scr_page, screen_addr};
        end else begin
            va = {2'b00, cpu_page, bus.a[13:0]};
        end
    end

    // --------------------------------------------------
    // RAM strobes
    // --------------------------------------------------
    always_ff @(posedge clk28 or negedge usrrst_n) begin
        if (!usrrst_n) begin
            n_vrd <= 1'b1;
            n_vwr <= 1'b1;
            scr_phase <= 1'b0;
        end else begin
            n_vrd <= ~(scr_grant | cpu_ram_rd);
            n_vwr <= ~(cpu_ram_wr & ~cpu_ram_rd);
            scr_phase <= scr_grant;
        end
    end

    assign vd_out = bus.d;

    // CPU data bus, ROM drives it on its own
    assign xd_out = d_out_active ? d_out : vd_in;
    assign xd_oe = d_out_active | cpu_ram_rd;

endmodule

// File: src/zx_ula.sv
`timescale 1ns/1ps

/*
 * Reduced ZX Spectrum ULA, pin-level top with bus decode and block wiring
 */
module zx_ula #(
    parameter int INT_LEN = 32
) (
    input  logic             clk28,
    input  logic             usrrst_n,
    input  zx_pkg::machine_t machine,
    input  logic [15:0]      xa,
    input  logic [7:0]       xd_in,
    input  logic             n_mreq,
    input  logic             n_iorq,
    input  logic             n_rd,
    input  logic             n_wr,
    input  logic             n_m1,
    input  logic             n_rfsh,
    input  logic [4:0]       kd,
    input  logic [7:0]       vd_in,
    output logic [7:0]       xd_out,
    output logic             xd_oe,
    output logic             clkcpu,
    output logic             n_int,
    output logic [18:0]      va,
    output logic [7:0]       vd_out,
    output logic             n_vrd,
    output logic             n_vwr,
    output logic             n_romcs,
    output logic [15:14]     ra,
    output logic [1:0]       r,
    output logic [1:0]       g,
    output logic [1:0]       b,
    output logic             hsync,
    output logic             vsync,
    output logic             beeper
);

    logic [8:0]  hc;
    logic [8:0]  vc;
    logic [2:0]  border;
    logic        screen_fetch;
    logic [13:0] screen_addr;
    logic        fetch_allow;
    logic [7:0]  fetch_data;
    logic [2:0]  rampage;
    logic        screenpage;
    logic        rompage;
    logic [7:0]  ports_dout;
    logic        ports_dout_active;

    // --------------------------------------------------
    // CPU bus
    // --------------------------------------------------
    cpu_bus bus ();

    assign bus.a = xa;
    assign bus.d = xd_in;
    assign bus.mreq = ~n_mreq;
    assign bus.iorq = ~n_iorq;
    assign bus.rd = ~n_rd;
    assign bus.wr = ~n_wr;
    assign bus.m1 = ~n_m1;
    assign bus.rfsh = ~n_rfsh;
    assign bus.ioreq = ~n_iorq & n_m1;

    // --------------------------------------------------
    // Blocks
    // --------------------------------------------------
    screen screen0 (
        .clk28(clk28),
        .usrrst_n(usrrst_n),
        .machine(machine),
        .border(border),
        .fetch_allow(fetch_allow),
        .fetch_data(fetch_data),
        .hc(hc),
        .vc(vc),
        .ck7(),
        .hsync(hsync),
        .vsync(vsync),
        .r(r),
        .g(g),
        .b(b),
        .fetch(screen_fetch),
        .addr(screen_addr)
    );

    cpucontrol #(
        .INT_LEN(INT_LEN)
    ) cpucontrol0 (
        .clk28(clk28),
        .usrrst_n(usrrst_n),
        .hc(hc),
        .vc(vc),
        .bus(bus),
        .clkcpu(clkcpu),
        .n_int(n_int)
    );

    ports ports0 (
        .clk28(clk28),
        .usrrst_n(usrrst_n),
        .bus(bus),
        .kd(kd),
        .border(border),
        .beeper(beeper),
        .rampage(rampage),
        .screenpage(screenpage),
        .rompage(rompage),
        .d_out(ports_dout),
        .d_out_active(ports_dout_active)
    );

    memcontrol memcontrol0 (
        .clk28(clk28),
        .usrrst_n(usrrst_n),
        .bus(bus),
        .screen_fetch(screen_fetch),
        .screen_addr(screen_addr),
        .rampage(rampage),
        .screenpage(screenpage),
        .rompage(rompage),
        .vd_in(vd_in),
        .d_out(ports_dout),
        .d_out_active(ports_dout_active),
        .fetch_allow(fetch_allow),
        .fetch_data(fetch_data),
        .va(va),
        .vd_out(vd_out),
        .n_vrd(n_vrd),
        .n_vwr(n_vwr),
        .n_romcs(n_romcs),
        .ra(ra),
        .xd_out(xd_out),
        .xd_oe(xd_oe)
    );

endmodule

// File: tests/zx_ula_properties.sv
`timescale 1ns/1ps

/*
 * Bus and strobe assertions for the ULA top level
 */
module zx_ula_properties (
    input logic       clk28,
    input logic       usrrst_n,
    input logic       n_rd,
    input logic       xd_oe,
    input logic       n_vrd,
    input logic       n_vwr,
    input logic       n_int,
    input logic [8:0] vc
);

    // CPU data bus only driven during a read
    oe_needs_rd: assert property (@(posedge clk28) disable iff (!usrrst_n)
        n_rd |-> !xd_oe)
        else $error("xd_oe high while n_rd is high");

    rd_wr_exclusive: assert property (@(posedge clk28) disable iff (!usrrst_n)
        !(!n_vrd && !n_vwr))
        else $error("n_vrd and n_vwr low together");

    // Interrupt pulse lives on the first line
    int_in_line_zero: assert property (@(posedge clk28) disable iff (!usrrst_n)
        (vc != 9'd0) |-> n_int)
        else $error("n_int low outside vc = 0");

endmodule

bind zx_ula zx_ula_properties props (
    .clk28(clk28),
    .usrrst_n(usrrst_n),
    .n_rd(n_rd),
    .xd_oe(xd_oe),
    .n_vrd(n_vrd),
    .n_vwr(n_vwr),
    .n_int(n_int),
    .vc(vc)
);

// File: tests/tb_zx_ula.sv
`timescale 1ns/1ps

/*
 * Directed testbench for the ULA top level with bus cycle tasks, checks and watchdog
 */
module tb_zx_ula;
    import zx_pkg::*;

    localparam int INT_LEN = 32;
    localparam int LINE_CLKS = 4 * 448;
    localparam int FRAME_48 = LINE_CLKS * 312;
    localparam int FRAME_PENT = LINE_CLKS * 320;
    localparam int BORDER_LIMIT = 2 * LINE_CLKS;
    localparam int FRAME_LIMIT = FRAME_PENT + 64;
    localparam int WATCHDOG_CYCLES = 5 * FRAME_PENT;

    logic        clk28;
    logic        usrrst_n;
    machine_t    machine;
    logic [15:0] xa;
    logic [7:0]  xd_in;
    logic        n_mreq;
    logic        n_iorq;
    logic        n_rd;
    logic        n_wr;
    logic        n_m1;
    logic        n_rfsh;
    logic [4:0]  kd;
    logic [7:0]  vd_in;
    logic [7:0]  xd_out;
    logic        xd_oe;
    logic        clkcpu;
    logic        n_int;
    logic [18:0] va;
    logic [7:0]  vd_out;
    logic        n_vrd;
    logic        n_vwr;
    logic        n_romcs;
    logic [15:14] ra;
    logic [1:0]  r;
    logic [1:0]  g;
    logic [1:0]  b;
    logic        hsync;
    logic        vsync;
    logic        beeper;

    int          err_cnt = 0;
    int          chk_cnt = 0;
    int unsigned cycle_cnt = 0;
    int unsigned cpu_rises = 0;
    int unsigned vsync_falls = 0;
    logic        clkcpu_q;
    logic        vsync_q;

    // Values seen during the last bus cycle
    logic [18:0] s_va;
    logic [7:0]  s_xd;
    logic        s_oe;
    logic        s_vrd;
    logic        s_vwr;
    logic        s_romcs;
    logic [1:0]  s_ra;
    logic [7:0]  s_vdout;

    zx_ula #(
        .INT_LEN(INT_LEN)
    ) UUT (
        .clk28(clk28), .usrrst_n(usrrst_n), .machine(machine),
        .xa(xa), .xd_in(xd_in), .n_mreq(n_mreq), .n_iorq(n_iorq),
        .n_rd(n_rd), .n_wr(n_wr), .n_m1(n_m1), .n_rfsh(n_rfsh),
        .kd(kd), .vd_in(vd_in), .xd_out(xd_out), .xd_oe(xd_oe),
        .clkcpu(clkcpu), .n_int(n_int), .va(va), .vd_out(vd_out),
        .n_vrd(n_vrd), .n_vwr(n_vwr), .n_romcs(n_romcs), .ra(ra),
        .r(r), .g(g), .b(b), .hsync(hsync), .vsync(vsync), .beeper(beeper)
    );

    initial clk28 = 1'b0;
    always #20 clk28 = ~clk28;

    always @(posedge clk28) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Edge counts of the CPU clock and the frame sync
    always @(posedge clk28) begin
        clkcpu_q <= clkcpu;
        vsync_q <= vsync;
        if (clkcpu === 1'b1 && clkcpu_q === 1'b0) begin
            cpu_rises <= cpu_rises + 1;
        end
        if (vsync === 1'b0 && vsync_q === 1'b1) begin
            vsync_falls <= vsync_falls + 1;
        end
    end

    // --------------------------------------------------
    // Checks and bus cycles
    // --------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    task automatic apply_reset(input machine_t m);
        @(negedge clk28);
        usrrst_n = 1'b0;
        machine = m;
        repeat (4) @(negedge clk28);
        usrrst_n = 1'b1;
    endtask

    task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
        @(negedge clk28);
        xa = addr;
        xd_in = data;
        n_iorq = 1'b0;
        n_wr = 1'b0;
        repeat (3) @(negedge clk28);
        n_iorq = 1'b1;
        n_wr = 1'b1;
        @(negedge clk28);
    endtask

    task automatic io_read(input logic [15:0] addr);
        @(negedge clk28);
        xa = addr;
        n_iorq = 1'b0;
        n_rd = 1'b0;
        @(negedge clk28);
        s_xd = xd_out;
        s_oe = xd_oe;
        n_iorq = 1'b1;
        n_rd = 1'b1;
        @(negedge clk28);
    endtask

    task automatic sample_mem();
        s_va = va;
        s_xd = xd_out;
        s_oe = xd_oe;
        s_vrd = n_vrd;
        s_vwr = n_vwr;
        s_romcs = n_romcs;
        s_ra = ra;
        s_vdout = vd_out;
    endtask

    task automatic mem_read(input logic [15:0] addr, input logic [7:0] vdata);
        @(negedge clk28);
        xa = addr;
        vd_in = vdata;
        n_mreq = 1'b0;
        n_rd = 1'b0;
        @(negedge clk28);
        sample_mem();
        n_mreq = 1'b1;
        n_rd = 1'b1;
        @(negedge clk28);
    endtask

    task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
        @(negedge clk28);
        xa = addr;
        xd_in = data;
        n_mreq = 1'b0;
        n_wr = 1'b0;
        @(negedge clk28);
        sample_mem();
        n_mreq = 1'b1;
        n_wr = 1'b1;
        @(negedge clk28);
    endtask

    // hsync sits in the right-hand border of every line
    task automatic wait_border();
        int n;
        n = 0;
        @(negedge clk28);
        while (hsync !== 1'b0 && n < BORDER_LIMIT) begin
            @(negedge clk28);
            n++;
        end
        if (hsync !== 1'b0) begin
            $display("Border area not reached, hsync stayed high for two lines");
            err_cnt++;
        end
    endtask

    task automatic wait_int(input logic level, output int unsigned at);
        int n;
        n = 0;
        @(negedge clk28);
        while (n_int !== level && n < FRAME_LIMIT) begin
            @(negedge clk28);
            n++;
        end
        at = cycle_cnt;
        if (n_int !== level) begin
            $display("n_int did not reach %b within one frame", level);
            err_cnt++;
        end
    endtask

    task automatic check_border(input logic [2:0] colour);
        check_value("r", r, {2{colour[1]}});
        check_value("g", g, {2{colour[2]}});
        check_value("b", b, {2{colour[0]}});
    endtask

    task automatic check_paging(input logic [7:0] pg);
        logic [13:0] off;
        off = $urandom & 14'h3fff;
        mem_read({2'b11, off}, 8'h00);
        check_value("va", s_va, {2'b00, pg[2:0], off});
        off = $urandom & 14'h3fff;
        mem_read({2'b00, off}, 8'h00);
        check_value("n_romcs", s_romcs, 1'b0);
        check_value("ra", s_ra, {1'b0, pg[4]});
        check_value("xd_oe", s_oe, 1'b0);
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic test_reset_state();
        int e;
        e = err_cnt;
        apply_reset(MACHINE_48);
        @(negedge clk28);
        check_value("n_int", n_int, 1'b1);
        check_value("n_vrd", n_vrd, 1'b1);
        check_value("n_vwr", n_vwr, 1'b1);
        check_value("xd_oe", xd_oe, 1'b0);
        check_value("beeper", beeper, 1'b0);
        wait_border();
        check_border(3'd0);
        finish_test("reset_state", e);
    endtask

    task automatic test_port_fe();
        int e;
        logic [7:0] data;
        logic [4:0] keys;
        e = err_cnt;
        data = $urandom;
        io_write(16'hfefe, data);
        check_value("beeper", beeper, data[4]);
        wait_border();
        check_border(data[2:0]);
        keys = $urandom;
        kd = keys;
        io_read(16'hfefe);
        check_value("xd_out", s_xd, {3'b111, keys});
        check_value("xd_oe", s_oe, 1'b1);
        finish_test("port_fe", e);
    endtask

    task automatic test_paging();
        int e;
        logic [7:0] pg1;
        logic [7:0] pg2;
        e = err_cnt;
        pg1 = $urandom & 8'h1f;
        io_write(16'h7ffd, pg1);
        check_paging(pg1);
        // Bit 5 locks the mapping
        pg2 = $urandom | 8'h20;
        io_write(16'h7ffd, pg2);
        check_paging(pg2);
        io_write(16'h7ffd, ~pg2 & 8'h1f);
        check_paging(pg2);
        finish_test("paging", e);
    endtask

    task automatic test_ram_access();
        int e;
        logic [13:0] off;
        logic [7:0] wdata;
        logic [7:0] rdata;
        e = err_cnt;
        off = $urandom & 14'h3fff;
        wdata = $urandom;
        rdata = $urandom;
        mem_write({2'b01, off}, wdata);
        check_value("n_vwr", s_vwr, 1'b0);
        check_value("n_vrd", s_vrd, 1'b1);
        check_value("va", s_va, {2'b00, 3'd5, off});
        check_value("vd_out", s_vdout, wdata);
        mem_read({2'b01, off}, rdata);
        check_value("n_vrd", s_vrd, 1'b0);
        check_value("n_vwr", s_vwr, 1'b1);
        check_value("va", s_va, {2'b00, 3'd5, off});
        check_value("xd_out", s_xd, rdata);
        check_value("xd_oe", s_oe, 1'b1);
        finish_test("ram_access", e);
    endtask

    task automatic test_frame_int(input machine_t m, input int frame_clks);
        int e;
        int unsigned t_fall;
        int unsigned t_rise;
        int unsigned t_next;
        int unsigned c_fall;
        int unsigned v_fall;
        e = err_cnt;
        apply_reset(m);
        wait_int(1'b0, t_fall);
        c_fall = cpu_rises;
        v_fall = vsync_falls;
        wait_int(1'b1, t_rise);
        wait_int(1'b0, t_next);
        check_value("n_int low time", t_rise - t_fall, INT_LEN * 8);
        check_value("n_int period", t_next - t_fall, frame_clks);
        // One CPU clock per eight clk28 cycles over a whole frame
        check_value("clkcpu rises", cpu_rises - c_fall, frame_clks / 8);
        check_value("vsync pulses", vsync_falls - v_fall, 1);
        finish_test(m == MACHINE_PENT ? "frame_int_pent" : "frame_int_48", e);
    endtask

    // --------------------------------------------------
    // Main sequence and watchdog
    // --------------------------------------------------
    initial begin
        usrrst_n = 1'b0;
        machine = MACHINE_48;
        xa = 16'h0000;
        xd_in = 8'h00;
        n_mreq = 1'b1;
        n_iorq = 1'b1;
        n_rd = 1'b1;
        n_wr = 1'b1;
        n_m1 = 1'b1;
        n_rfsh = 1'b1;
        kd = 5'h1f;
        vd_in = 8'h00;
        void'($urandom(32'hc255));

        test_reset_state();
        test_port_fe();
        test_paging();
        test_ram_access();
        test_frame_int(MACHINE_48, FRAME_48);
        test_frame_int(MACHINE_PENT, FRAME_PENT);

        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk28);
        $display("Watchdog expired after %0d clock cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: vlog.f
src/zx_pkg.sv
src/cpu_bus.sv
src/screen.sv
src/cpucontrol.sv
src/ports.sv
src/memcontrol.sv
src/zx_ula.sv
tests/zx_ula_properties.sv
tests/tb_zx_ula.sv

// File: Bender.yml
package:
  name: zx_ula

sources:
  - src/zx_pkg.sv
  - src/cpu_bus.sv
  - src/screen.sv
  - src/cpucontrol.sv
  - src/ports.sv
  - src/memcontrol.sv
  - src/zx_ula.sv
  - target: test
    files:
      - tests/zx_ula_properties.sv
      - tests/tb_zx_ula.sv
